/* common/commit_pkg.sv */
// Shared types of the commit stage: result words, register indices, tags and buffer payloads

package commit_pkg;

    // ======================================================================
    // Scalar widths
    // ======================================================================

    // Number of execution lanes, and so of commit buffers
    // The datapath is written for exactly two
    localparam int N_LANES = 2;

    // One integer result as produced by an execution lane
    typedef logic [31:0] data_word_t;

    // Architectural register index, register 0 is hardwired to zero
    typedef logic [4:0] reg_addr_t;

    // Reorder buffer tag that names one instruction in flight
    typedef logic [5:0] rob_tag_t;

    // ======================================================================
    // Structured payloads
    // ======================================================================

    // Instruction identity that travels beside each result
    typedef struct packed {
        rob_tag_t  rob_tag;
        reg_addr_t reg_dest;
    } instr_packet_t;

    // One buffer slot, which is also the write-back payload
    typedef struct packed {
        data_word_t    result;
        instr_packet_t ipacket;
    } commit_entry_t;

    // Answer to one forwarding lookup from the issue stage
    typedef struct packed {
        data_word_t value;
        logic       valid;
    } fwd_reply_t;

endpackage : commit_pkg

/* commit_buffer/commit_buffer.sv */
// Per-lane commit buffer: result FIFO plus forwarding copies, tag table and validity bits

module commit_buffer
    import commit_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,

    // Push from the producer lane and pull from the commit arbiter
    input  logic                write_i,
    input  logic                read_i,
    input  data_word_t          result_i,
    input  instr_packet_t       ipacket_i,
    output commit_entry_t       head_o,

    // Cross-invalidation from the other lane's writes
    input  logic                invalidate_i,
    input  reg_addr_t           invalid_reg_i,

    // Forwarding lookups, one per issue source port
    input  reg_addr_t     [1:0] fwd_src_i,
    output fwd_reply_t    [1:0] fwd_o,

    // Status flags, both registered
    output logic                full_o,
    output logic                empty_o
);

    // Pointers wrap naturally because the depth is a power of two
    localparam int PTR_W  = $clog2(BUFFER_DEPTH);
    localparam int N_REGS = 2 ** $bits(reg_addr_t);

    typedef logic [PTR_W-1:0] buf_ptr_t;

    buf_ptr_t write_ptr_q;
    buf_ptr_t read_ptr_q;
    buf_ptr_t write_ptr_inc;
    buf_ptr_t read_ptr_inc;

    // A write that actually lands, flush discards writes in its own cycle
    logic push;

    assign push          = write_i && !flush_i;
    assign write_ptr_inc = write_ptr_q + 1'b1;
    assign read_ptr_inc  = read_ptr_q + 1'b1;

    // ======================================================================
    // FIFO pointers and status flags
    // ======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            write_ptr_q <= '0;
            read_ptr_q  <= '0;
        end else begin
            if (write_i) begin
                write_ptr_q <= write_ptr_inc;
            end
            if (read_i) begin
                read_ptr_q <= read_ptr_inc;
            end
        end
    end

    // Flags only move when exactly one side is active
    // A simultaneous push and pull leaves the occupancy unchanged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            if (read_i && !write_i) begin
                full_o  <= 1'b0;
                // Empty once the read pointer catches the write pointer
                empty_o <= (read_ptr_inc == write_ptr_q);
            end else if (write_i && !read_i) begin
                empty_o <= 1'b0;
                // Full once the write pointer wraps onto the read pointer
                full_o  <= (write_ptr_inc == read_ptr_q);
            end
        end
    end

    // ======================================================================
    // Result storage
    // ======================================================================

    commit_entry_t fifo_mem [BUFFER_DEPTH];

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[write_ptr_q] <= '{result: result_i, ipacket: ipacket_i};
        end
    end

    // The head is visible as soon as the slot is written
    assign head_o = fifo_mem[read_ptr_q];

    // ======================================================================
    // Forwarding state
    // ======================================================================

    // Tag of the newest instruction that wrote each destination
    rob_tag_t tag_mem [N_REGS];

    always_ff @(posedge clk_i) begin
        if (push) begin
            tag_mem[ipacket_i.reg_dest] <= ipacket_i.rob_tag;
        end
    end

    // Set while this buffer holds the newest uncommitted copy of a register
    logic [N_REGS-1:0] valid_q;
    logic [N_REGS-1:0] valid_d;

    // The entry leaving the buffer is the newest producer of its register
    logic pull_latest;

    assign pull_latest = read_i
        && (tag_mem[head_o.ipacket.reg_dest] == head_o.ipacket.rob_tag);

    // Later updates win on the same bit, so a new write survives the
    // retirement of the previous producer of the same register
    always_comb begin
        valid_d = valid_q;
        if (pull_latest) begin
            valid_d[head_o.ipacket.reg_dest] = 1'b0;
        end
        if (write_i) begin
            valid_d[ipacket_i.reg_dest] = 1'b1;
        end
        // The other lane now owns the newest copy of this register
        if (invalidate_i) begin
            valid_d[invalid_reg_i] = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // ======================================================================
    // Forwarding read ports
    // ======================================================================

    // One value copy per source port gives each lookup its own read port
    for (genvar p = 0; p < 2; p++) begin : gen_fwd_port
        data_word_t fwd_mem [N_REGS];

        always_ff @(posedge clk_i) begin
            if (push) begin
                fwd_mem[ipacket_i.reg_dest] <= result_i;
            end
        end

        // Register 0 always answers zero and is always valid
        always_comb begin
            if (fwd_src_i[p] == '0) begin
                fwd_o[p].value = '0;
                fwd_o[p].valid = 1'b1;
            end else begin
                fwd_o[p].value = fwd_mem[fwd_src_i[p]];
                fwd_o[p].valid = valid_q[fwd_src_i[p]];
            end
        end
    end

endmodule : commit_buffer

/* src/commit_arbiter.sv */
// Round-robin commit arbiter that pulls one buffer head per cycle into write-back

module commit_arbiter
    import commit_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Buffer status and head entries
    input  logic          [N_LANES-1:0] empty_i,
    input  commit_entry_t [N_LANES-1:0] head_i,

    // Pull strobes back to the buffers
    output logic          [N_LANES-1:0] read_o,

    // Write-back port, always accepted
    output logic                        commit_valid_o,
    output commit_entry_t               commit_entry_o
);

    // Which buffer wins when both hold entries
    typedef enum logic {
        PRIO_BUF0 = 1'b0,
        PRIO_BUF1 = 1'b1
    } prio_t;

    prio_t prio_q;

    logic both_ready;

    assign both_ready = !empty_i[0] && !empty_i[1];

    // ======================================================================
    // Grant
    // ======================================================================

    // At most one strobe is raised, so the heads can be muxed directly
    always_comb begin
        read_o = '0;
        if (both_ready) begin
            read_o[prio_q] = 1'b1;
        end else if (!empty_i[0]) begin
            read_o[0] = 1'b1;
        end else if (!empty_i[1]) begin
            read_o[1] = 1'b1;
        end
    end

    assign commit_valid_o = |read_o;
    assign commit_entry_o = read_o[1] ? head_i[1] : head_i[0];

    // ======================================================================
    // Priority
    // ======================================================================

    // Priority only rotates on a contested cycle
    // A lone non-empty buffer is served without disturbing the order
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            prio_q <= PRIO_BUF0;
        end else if (both_ready) begin
            prio_q <= (prio_q == PRIO_BUF0) ? PRIO_BUF1 : PRIO_BUF0;
        end
    end

endmodule : commit_arbiter

/* src/forward_select.sv */
// Forwarding merge that picks the valid answer of the two commit buffers per source port

module forward_select
    import commit_pkg::*;
(
    // Answers from buffer 0 and buffer 1
    input  fwd_reply_t [1:0] reply_a_i,
    input  fwd_reply_t [1:0] reply_b_i,

    // Merged answers to the issue stage
    output fwd_reply_t [1:0] fwd_o
);

    // Cross-invalidation keeps at most one valid copy of a nonzero register
    // Both buffers answer register 0, and lane 0 is taken then
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (reply_a_i[p].valid) begin
                fwd_o[p] = reply_a_i[p];
            end else if (reply_b_i[p].valid) begin
                fwd_o[p] = reply_b_i[p];
            end else begin
                // Neither buffer holds the register, the issue stage
                // must read it from the register file
                fwd_o[p].value = '0;
                fwd_o[p].valid = 1'b0;
            end
        end
    end

endmodule : forward_select

/* src/commit_stage.sv */
// Commit stage top: two lane buffers, round-robin write-back and merged forwarding

module commit_stage
    import commit_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Producer lanes, lane 0 arithmetic and lane 1 load/store
    input  logic          [N_LANES-1:0] lane_write_i,
    input  data_word_t    [N_LANES-1:0] lane_result_i,
    input  instr_packet_t [N_LANES-1:0] lane_packet_i,
    output logic          [N_LANES-1:0] lane_full_o,

    // Write-back to the register file
    output logic                        commit_valid_o,
    output commit_entry_t               commit_entry_o,

    // Forwarding to the issue stage
    input  reg_addr_t     [1:0]         fwd_src_i,
    output fwd_reply_t    [1:0]         fwd_o
);

    logic          [N_LANES-1:0] buf_empty;
    logic          [N_LANES-1:0] buf_read;
    commit_entry_t [N_LANES-1:0] buf_head;

    // Forwarding answers of each buffer, indexed by lane
    fwd_reply_t [1:0] buf_fwd [N_LANES];

    // ======================================================================
    // Lane buffers
    // ======================================================================

    // Each buffer is invalidated by the writes of the other lane
    for (genvar k = 0; k < N_LANES; k++) begin : gen_lane
        commit_buffer #(
            .BUFFER_DEPTH (BUFFER_DEPTH)
        ) commit_buffer_inst (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .flush_i       (flush_i),
            .write_i       (lane_write_i[k]),
            .read_i        (buf_read[k]),
            .result_i      (lane_result_i[k]),
            .ipacket_i     (lane_packet_i[k]),
            .head_o        (buf_head[k]),
            .invalidate_i  (lane_write_i[N_LANES-1-k]),
            .invalid_reg_i (lane_packet_i[N_LANES-1-k].reg_dest),
            .fwd_src_i     (fwd_src_i),
            .fwd_o         (buf_fwd[k]),
            .full_o        (lane_full_o[k]),
            .empty_o       (buf_empty[k])
        );
    end

    // ======================================================================
    // Write-back and forwarding
    // ======================================================================

    commit_arbiter commit_arbiter_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .empty_i        (buf_empty),
        .head_i         (buf_head),
        .read_o         (buf_read),
        .commit_valid_o (commit_valid_o),
        .commit_entry_o (commit_entry_o)
    );

    forward_select forward_select_inst (
        .reply_a_i (buf_fwd[0]),
        .reply_b_i (buf_fwd[1]),
        .fwd_o     (fwd_o)
    );

endmodule : commit_stage

/* tests/tb_commit_stage.sv */
// Testbench for the commit stage that replays golden per-cycle stimulus and checks every output

module tb_commit_stage
    import commit_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ======================================================================
    // Golden file layout
    // ======================================================================

    localparam int    BUFFER_DEPTH = 8;
    localparam int    N_CYCLES     = 32;
    localparam int    N_FIELDS     = 21;
    localparam int    MAX_CYCLES   = N_CYCLES + 20;
    localparam string GOLDEN_FILE  = "tests/commit_stage_golden.txt";

    // Column positions within one golden line
    // Each lane owns four columns in the order write, tag, dest and result
    localparam int F_FLUSH   = 0;
    localparam int LANE_BASE = 1;
    localparam int SRC_BASE  = 9;
    localparam int F_CV      = 11;
    localparam int F_CTAG    = 12;
    localparam int F_CDST    = 13;
    localparam int F_CRES    = 14;
    localparam int FWD_BASE  = 15;
    localparam int FULL_BASE = 19;

    logic [31:0] golden_mem [N_CYCLES * N_FIELDS];

    logic                        clk_i;
    logic                        rst_n_i;
    logic                        flush_i;
    logic          [N_LANES-1:0] lane_write_i;
    data_word_t    [N_LANES-1:0] lane_result_i;
    instr_packet_t [N_LANES-1:0] lane_packet_i;
    logic          [N_LANES-1:0] lane_full_o;
    logic                        commit_valid_o;
    commit_entry_t               commit_entry_o;
    reg_addr_t     [1:0]         fwd_src_i;
    fwd_reply_t    [1:0]         fwd_o;

    int cycle_count = 0;
    int line_idx    = 0;

    commit_stage #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) commit_stage_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .lane_write_i   (lane_write_i),
        .lane_result_i  (lane_result_i),
        .lane_packet_i  (lane_packet_i),
        .lane_full_o    (lane_full_o),
        .commit_valid_o (commit_valid_o),
        .commit_entry_o (commit_entry_o),
        .fwd_src_i      (fwd_src_i),
        .fwd_o          (fwd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Ends a run that never reaches the last golden line
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles before the golden file was replayed",
                     cycle_count);
            abort_run();
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] golden_field(input int line, input int field);
        return golden_mem[line * N_FIELDS + field];
    endfunction

    // An unread or short file leaves X words behind
    task automatic load_golden();
        $readmemh(GOLDEN_FILE, golden_mem);
        foreach (golden_mem[i]) begin
            if ($isunknown(golden_mem[i])) begin
                $display("Golden file %s is missing or incomplete at word %0d", GOLDEN_FILE, i);
                abort_run();
            end
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t ns line=%0d %s expected=%b actual=%b",
                     $time, line_idx, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t ns line=%0d %s expected=%h actual=%h",
                     $time, line_idx, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_packet(input string name, input instr_packet_t expected,
                                input instr_packet_t actual);
        string exp_str;
        string act_str;
        if (actual !== expected) begin
            exp_str = $sformatf("tag %h dest %h", expected.rob_tag, expected.reg_dest);
            act_str = $sformatf("tag %h dest %h", actual.rob_tag, actual.reg_dest);
            $display("CHECK FAILED time=%0t ns line=%0d %s expected=%s actual=%s",
                     $time, line_idx, name, exp_str, act_str);
            abort_run();
        end
    endtask

    // Unpacks one golden line into whole vectors and drives each port once
    task automatic drive_line(input int line);
        logic          [N_LANES-1:0] write_v;
        data_word_t    [N_LANES-1:0] result_v;
        instr_packet_t [N_LANES-1:0] packet_v;
        reg_addr_t     [1:0]         src_v;
        for (int k = 0; k < N_LANES; k++) begin
            write_v[k]           = 1'(golden_field(line, LANE_BASE + 4 * k));
            packet_v[k].rob_tag  = rob_tag_t'(golden_field(line, LANE_BASE + 4 * k + 1));
            packet_v[k].reg_dest = reg_addr_t'(golden_field(line, LANE_BASE + 4 * k + 2));
            result_v[k]          = data_word_t'(golden_field(line, LANE_BASE + 4 * k + 3));
        end
        for (int p = 0; p < 2; p++) begin
            src_v[p] = reg_addr_t'(golden_field(line, SRC_BASE + p));
        end
        flush_i       <= 1'(golden_field(line, F_FLUSH));
        lane_write_i  <= write_v;
        lane_result_i <= result_v;
        lane_packet_i <= packet_v;
        fwd_src_i     <= src_v;
    endtask

    // Payloads are only compared when their valid flag is expected high
    task automatic check_line(input int line);
        instr_packet_t exp_packet;
        exp_packet.rob_tag  = rob_tag_t'(golden_field(line, F_CTAG));
        exp_packet.reg_dest = reg_addr_t'(golden_field(line, F_CDST));
        check_bit("commit_valid_o", 1'(golden_field(line, F_CV)), commit_valid_o);
        if (golden_field(line, F_CV) != 0) begin
            check_packet("commit_entry_o.ipacket", exp_packet, commit_entry_o.ipacket);
            check_word("commit_entry_o.result", data_word_t'(golden_field(line, F_CRES)),
                       commit_entry_o.result);
        end
        for (int p = 0; p < 2; p++) begin
            check_bit($sformatf("fwd_o[%0d].valid", p),
                      1'(golden_field(line, FWD_BASE + 2 * p)), fwd_o[p].valid);
            if (golden_field(line, FWD_BASE + 2 * p) != 0) begin
                check_word($sformatf("fwd_o[%0d].value", p),
                           data_word_t'(golden_field(line, FWD_BASE + 2 * p + 1)),
                           fwd_o[p].value);
            end
        end
        for (int k = 0; k < N_LANES; k++) begin
            check_bit($sformatf("lane_full_o[%0d]", k),
                      1'(golden_field(line, FULL_BASE + k)), lane_full_o[k]);
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Inputs change on the rising edge and outputs are sampled on the falling edge
    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        lane_write_i  = '0;
        lane_result_i = '0;
        lane_packet_i = '0;
        fwd_src_i     = '0;
        load_golden();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int line = 0; line < N_CYCLES; line++) begin
            @(posedge clk_i);
            line_idx = line;
            drive_line(line);
            @(negedge clk_i);
            check_line(line);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_commit_stage

/* tests/commit_stage_golden.txt */
// Inputs: flush wr0 tag0 dst0 res0 wr1 tag1 dst1 res1 src0 src1, all hex, one line per cycle
// Expected: cv ctag cdst cres fwd0_valid fwd0_value fwd1_valid fwd1_value full0 full1
// After reset
0 0 00 00 000 0 00 00 000 00 05 0 00 00 000 1 000 0 000 0 0
// Lane 0 alone, each entry commits the cycle after its write
0 1 01 01 0a1 0 00 00 000 01 02 0 00 00 000 0 000 0 000 0 0
0 1 02 02 0a2 0 00 00 000 01 02 1 01 01 0a1 1 0a1 0 000 0 0
0 1 03 03 0a3 0 00 00 000 01 02 1 02 02 0a2 0 000 1 0a2 0 0
0 0 00 00 000 0 00 00 000 02 03 1 03 03 0a3 0 000 1 0a3 0 0
0 0 00 00 000 0 00 00 000 03 00 0 00 00 000 0 000 1 000 0 0
// Both lanes busy, commits alternate and buffer 1 fills up
0 1 10 04 a06 1 20 10 b06 10 04 0 00 00 000 0 000 0 000 0 0
0 1 11 05 a07 1 21 11 b07 10 04 1 10 04 a06 1 b06 1 a06 0 0
0 0 00 00 000 1 22 12 b08 10 04 1 20 10 b06 1 b06 0 000 0 0
0 1 12 06 a09 1 23 13 b09 10 05 1 11 05 a07 0 000 1 a07 0 0
0 0 00 00 000 1 24 14 b10 11 06 1 21 11 b07 1 b07 1 a09 0 0
0 1 13 07 a11 1 25 15 b11 11 06 1 12 06 a09 0 000 1 a09 0 0
0 0 00 00 000 1 26 16 b12 12 07 1 22 12 b08 1 b08 1 a11 0 0
0 1 14 08 a13 1 27 17 b13 13 07 1 13 07 a11 1 b09 1 a11 0 0
0 0 00 00 000 1 28 18 b14 14 08 1 23 13 b09 1 b10 1 a13 0 0
0 1 15 09 a15 1 29 19 b15 15 08 1 14 08 a13 1 b11 1 a13 0 0
0 0 00 00 000 1 2a 1a b16 16 09 1 24 14 b10 1 b12 1 a15 0 0
0 1 16 0a a17 1 2b 1b b17 17 09 1 15 09 a15 1 b13 1 a15 0 0
0 0 00 00 000 1 2c 1c b18 18 0a 1 25 15 b11 1 b14 1 a17 0 0
0 1 17 0b a19 1 2d 1d b19 19 0a 1 16 0a a17 1 b15 1 a17 0 0
0 0 00 00 000 0 00 00 000 16 0b 1 26 16 b12 1 b12 1 a19 0 1
// Flush with writes in the same cycle, then everything is gone
1 1 3e 02 c21 1 3f 1e b21 1d 0b 1 17 0b a19 1 b19 1 a19 0 0
0 0 00 00 000 0 00 00 000 02 1e 0 00 00 000 0 000 0 000 0 0
// Priority restarts at lane 0, reg 06 moves from lane 0 to lane 1
0 1 30 03 c23 1 31 05 d23 03 05 0 00 00 000 0 000 0 000 0 0
0 1 32 06 c24 0 00 00 000 03 05 1 30 03 c23 1 c23 1 d23 0 0
0 0 00 00 000 1 33 06 d25 06 05 1 31 05 d23 1 c24 1 d23 0 0
0 0 00 00 000 0 00 00 000 06 05 1 32 06 c24 1 d25 0 000 0 0
0 0 00 00 000 0 00 00 000 06 00 1 33 06 d25 1 d25 1 000 0 0
// A lone commit leaves priority at lane 1
0 1 34 07 c28 1 35 08 d28 06 07 0 00 00 000 0 000 0 000 0 0
0 0 00 00 000 0 00 00 000 07 08 1 35 08 d28 1 c28 1 d28 0 0
0 0 00 00 000 0 00 00 000 07 08 1 34 07 c28 1 c28 0 000 0 0
0 0 00 00 000 0 00 00 000 07 00 0 00 00 000 0 000 1 000 0 0

/* flist.f */
common/commit_pkg.sv
commit_buffer/commit_buffer.sv
src/commit_arbiter.sv
src/forward_select.sv
src/commit_stage.sv
tests/tb_commit_stage.sv

/* Bender.yml */
package:
  name: commit_stage

dependencies: {}

sources:
  # Shared types
  - common/commit_pkg.sv
  # Design
  - commit_buffer/commit_buffer.sv
  - src/commit_arbiter.sv
  - src/forward_select.sv
  - src/commit_stage.sv
  # Testbench
  - target: test
    files:
      - tests/tb_commit_stage.sv
